// ==== Bender.yml ====
package:
  name: squash_sub

export_include_dirs:
  - hdl

sources:
  - target: rtl
    include_dirs:
      - hdl
    files:
      - hdl/squash_pkg.sv
      - hdl/seq_age.sv
      - hdl/squash_filter.sv
      - hdl/squash_arb_chain.sv
      - hdl/squash_unit.sv
  - target: bench
    include_dirs:
      - hdl
    files:
      - bench/squash_checker.sv
      - bench/squash_unit_tb.sv

// ==== bench/squash_checker.sv ====
// --------------------
// Reference model and scoreboard for the squash arbitration stage
// Samples DUT inputs on the rising edge, compares the grant on the falling edge
// Prints one line per stimulus row and keeps error and row counts
// --------------------

`timescale 1ns/1ps

`include "squash_params.svh"

module squash_checker
  import squash_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  // DUT inputs
  input  logic     arb_val     [`SQUASH_NUM_SRC],
  input  seq_num_t arb_seq_num [`SQUASH_NUM_SRC],
  input  target_t  arb_target  [`SQUASH_NUM_SRC],
  input  logic     commit_val,
  input  seq_num_t commit_seq_num,

  // DUT outputs
  input  logic     gnt_val,
  input  seq_num_t gnt_seq_num,
  input  target_t  gnt_target,
  input  logic [$clog2(`SQUASH_NUM_SRC)-1:0] gnt_src,

  // Row tag from the stimulus loop
  input  int       row_num,
  input  logic     row_act,

  output int       rows_done,
  output int       err_cnt,
  output int       chk_cnt
);

  localparam int src_bits = $clog2(`SQUASH_NUM_SRC);

  // Model of head and filter
  seq_num_t            m_head;
  logic                m_hold;
  seq_num_t            m_rec;

  // Expected grant for the cycle after the sample
  logic                exp_val;
  seq_num_t            exp_seq;
  target_t             exp_tgt;
  logic [src_bits-1:0] exp_src;

  // Row that the expected grant belongs to
  logic                smp_act;
  int                  smp_row;
  logic                armed = 1'b0;

  initial begin
    rows_done = 0;
    err_cnt   = 0;
    chk_cnt   = 0;
  end

  // --------------------
  // Model steps once per edge
  // --------------------

  always @(posedge clk) begin : model
    logic     n_val;
    seq_num_t n_seq;
    target_t  n_tgt;
    int       n_src;
    seq_age_t n_age;
    seq_age_t a;
    seq_age_t rec_a;
    logic     live;
    if (!rst_n) begin
      m_head  = '0;
      m_hold  = 1'b0;
      m_rec   = '0;
      exp_val = 1'b0;
      smp_act = 1'b0;
      armed   = 1'b1;
    end else begin
      // Distance of the recorded squash from the old head
      rec_a = m_rec - m_head;
      n_val = 1'b0;
      n_seq = '0;
      n_tgt = '0;
      n_src = 0;
      n_age = '0;
      // Oldest live source wins with the lowest index on a tie
      for (int i = 0; i < `SQUASH_NUM_SRC; i++) begin
        a    = arb_seq_num[i] - m_head;
        live = arb_val[i] && (!m_hold || (a < rec_a));
        if (live && (!n_val || (a < n_age))) begin
          n_val = 1'b1;
          n_age = a;
          n_seq = arb_seq_num[i];
          n_tgt = arb_target[i];
          n_src = i;
        end
      end
      // The grant now on the outputs updates the filter
      if (exp_val && (!m_hold || (seq_age_t'(exp_seq - m_head) < rec_a))) begin
        m_hold = 1'b1;
        m_rec  = exp_seq;
      end else if (commit_val && m_hold && (commit_seq_num == m_rec)) begin
        m_hold = 1'b0;
      end
      if (commit_val) begin
        m_head = commit_seq_num + 1'b1;
      end
      exp_val = n_val;
      exp_seq = n_seq;
      exp_tgt = n_tgt;
      exp_src = src_bits'(n_src);
      smp_act = row_act;
      smp_row = row_num;
    end
  end

  // --------------------
  // Compare
  // --------------------

  function automatic string where_str();
    return smp_act ? $sformatf("row %0d", smp_row) : "idle cycle";
  endfunction

  always @(negedge clk) begin : compare
    logic bad;
    if (armed) begin
      bad = 1'b0;
      if (gnt_val !== exp_val) begin
        bad = 1'b1;
        $display("error at %0t ns: %s gnt_val %b, expected %b",
                 $time, where_str(), gnt_val, exp_val);
      end else if (exp_val) begin
        if (gnt_seq_num !== exp_seq) begin
          bad = 1'b1;
          $display("error at %0t ns: %s gnt_seq_num %0d, expected %0d",
                   $time, where_str(), gnt_seq_num, exp_seq);
        end
        if (gnt_target !== exp_tgt) begin
          bad = 1'b1;
          $display("error at %0t ns: %s gnt_target %h, expected %h",
                   $time, where_str(), gnt_target, exp_tgt);
        end
        if (gnt_src !== exp_src) begin
          bad = 1'b1;
          $display("error at %0t ns: %s gnt_src %0d, expected %0d",
                   $time, where_str(), gnt_src, exp_src);
        end
      end
      chk_cnt++;
      if (bad) begin
        err_cnt++;
      end
      // One line per finished row
      if (smp_act) begin
        if (exp_val) begin
          $display("row %0d: grant src %0d seq %0d, %s", smp_row, exp_src, exp_seq,
                   bad ? "mismatch" : "ok");
        end else begin
          $display("row %0d: no grant, %s", smp_row, bad ? "mismatch" : "ok");
        end
        rows_done++;
      end
    end
  end

endmodule

// ==== bench/squash_unit_tb.sv ====
// --------------------
// Testbench for the squash arbitration stage
// Applies a table of directed and random rows, one idle cycle apart
// Grants are compared by the checker module
// --------------------

`timescale 1ns/1ps

`include "squash_params.svh"

module squash_unit_tb
  import squash_pkg::*;
();

  localparam int num_src     = `SQUASH_NUM_SRC;
  localparam int clk_period  = 40;
  localparam int row_timeout = 20;
  localparam int num_random  = 40;

  typedef logic [num_src-1:0] src_mask_t;

  // One stimulus row
  typedef struct packed {
    src_mask_t                  val;
    seq_num_t [num_src-1:0]     seq;
    target_t  [num_src-1:0]     tgt;
    logic                       cval;
    seq_num_t                   cseq;
  } row_t;

  logic     clk;
  logic     rst_n;
  logic     arb_val     [num_src];
  seq_num_t arb_seq_num [num_src];
  target_t  arb_target  [num_src];
  logic     commit_val;
  seq_num_t commit_seq_num;
  logic     gnt_val;
  seq_num_t gnt_seq_num;
  target_t  gnt_target;
  logic [$clog2(`SQUASH_NUM_SRC)-1:0] gnt_src;

  // Row tag and checker counts
  int       row_num;
  logic     row_act;
  int       rows_done;
  int       err_cnt;
  int       chk_cnt;

  row_t     rows [$];
  logic     timed_out;

  // --------------------
  // Clock, DUT, checker
  // --------------------

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  squash_unit i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .arb_val        (arb_val),
    .arb_seq_num    (arb_seq_num),
    .arb_target     (arb_target),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num),
    .gnt_val        (gnt_val),
    .gnt_seq_num    (gnt_seq_num),
    .gnt_target     (gnt_target),
    .gnt_src        (gnt_src)
  );

  squash_checker i_checker (
    .clk            (clk),
    .rst_n          (rst_n),
    .arb_val        (arb_val),
    .arb_seq_num    (arb_seq_num),
    .arb_target     (arb_target),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num),
    .gnt_val        (gnt_val),
    .gnt_seq_num    (gnt_seq_num),
    .gnt_target     (gnt_target),
    .gnt_src        (gnt_src),
    .row_num        (row_num),
    .row_act        (row_act),
    .rows_done      (rows_done),
    .err_cnt        (err_cnt),
    .chk_cnt        (chk_cnt)
  );

  // --------------------
  // Table building
  // --------------------

  function automatic void add_row(int val, int s0, int s1, int s2,
                                  int t0, int t1, int t2, int cv, int cs);
    row_t r;
    r.val    = src_mask_t'(val);
    r.seq[0] = seq_num_t'(s0);
    r.seq[1] = seq_num_t'(s1);
    r.seq[2] = seq_num_t'(s2);
    r.tgt[0] = target_t'(t0);
    r.tgt[1] = target_t'(t1);
    r.tgt[2] = target_t'(t2);
    r.cval   = (cv != 0);
    r.cseq   = seq_num_t'(cs);
    rows.push_back(r);
  endfunction

  function automatic void fill_random(int n);
    row_t r;
    for (int k = 0; k < n; k++) begin
      r.val = src_mask_t'($urandom);
      for (int i = 0; i < num_src; i++) begin
        r.seq[i] = seq_num_t'($urandom);
        r.tgt[i] = target_t'($urandom);
      end
      // Commit in about one row of four
      r.cval = (($urandom % 4) == 0);
      r.cseq = seq_num_t'($urandom);
      rows.push_back(r);
    end
  endfunction

  function automatic void build_table();
    // Reset, then a single source
    add_row(3'b001, 10, 0, 0, 'h1000, 'h0, 'h0, 0, 0);
    // Oldest by age, then a tie between sources 1 and 2
    add_row(3'b111, 8, 5, 7, 'h1100, 'h1101, 'h1102, 0, 0);
    add_row(3'b110, 0, 3, 3, 'h0, 'h1201, 'h1202, 0, 0);
    // Stale drop, then an older one replaces the record
    add_row(3'b111, 3, 4, 9, 'h1300, 'h1301, 'h1302, 0, 0);
    add_row(3'b011, 6, 2, 0, 'h1400, 'h1401, 'h0, 0, 0);
    add_row(3'b001, 2, 0, 0, 'h1500, 'h0, 'h0, 0, 0);
    // Commits up to the recorded squash release the filter
    add_row(3'b000, 0, 0, 0, 'h0, 'h0, 'h0, 1, 0);
    add_row(3'b000, 0, 0, 0, 'h0, 'h0, 'h0, 1, 1);
    add_row(3'b000, 0, 0, 0, 'h0, 'h0, 'h0, 1, 2);
    add_row(3'b001, 20, 0, 0, 'h1900, 'h0, 'h0, 0, 0);
    add_row(3'b010, 0, 25, 0, 'h0, 'h2001, 'h0, 0, 0);
    // Head moves near the top of the range
    add_row(3'b000, 0, 0, 0, 'h0, 'h0, 'h0, 1, 20);
    add_row(3'b000, 0, 0, 0, 'h0, 'h0, 'h0, 1, 59);
    // Wrapped numbers ranked by age
    add_row(3'b111, 62, 1, 60, 'h2300, 'h2301, 'h2302, 0, 0);
    add_row(3'b000, 0, 0, 0, 'h0, 'h0, 'h0, 1, 60);
    add_row(3'b011, 3, 63, 0, 'h2500, 'h2501, 'h0, 0, 0);
    add_row(3'b101, 62, 0, 0, 'h2600, 'h0, 'h2602, 0, 0);
    // Notification and release in the same cycle
    add_row(3'b111, 61, 61, 5, 'h2700, 'h2701, 'h2702, 1, 62);
  endfunction

  // --------------------
  // Row driving
  // --------------------

  task automatic apply_row(int idx);
    for (int i = 0; i < num_src; i++) begin
      arb_val[i]     = rows[idx].val[i];
      arb_seq_num[i] = rows[idx].seq[i];
      arb_target[i]  = rows[idx].tgt[i];
    end
    commit_val     = rows[idx].cval;
    commit_seq_num = rows[idx].cseq;
    row_num        = idx;
    row_act        = 1'b1;
  endtask

  task automatic drive_idle();
    for (int i = 0; i < num_src; i++) begin
      arb_val[i]     = 1'b0;
      arb_seq_num[i] = '0;
      arb_target[i]  = '0;
    end
    commit_val     = 1'b0;
    commit_seq_num = '0;
    row_act        = 1'b0;
  endtask

  // Waits until the checker has compared the row
  task automatic wait_row_checked(int idx, output logic ok);
    int cycles;
    cycles = 0;
    ok     = 1'b0;
    while (!ok && (cycles < row_timeout)) begin
      @(posedge clk);
      cycles++;
      if (rows_done > idx) begin
        ok = 1'b1;
      end
    end
    if (!ok) begin
      $display("timeout: row %0d was not checked within %0d cycles", idx, row_timeout);
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    logic ok;
    rst_n     = 1'b0;
    row_num   = 0;
    timed_out = 1'b0;
    drive_idle();
    void'($urandom(32'h22df_e1fb));
    build_table();
    fill_random(num_random);

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int idx = 0; idx < rows.size(); idx++) begin
      @(negedge clk);
      apply_row(idx);
      @(negedge clk);
      drive_idle();
      wait_row_checked(idx, ok);
      if (!ok) begin
        timed_out = 1'b1;
        break;
      end
    end

    $display("rows %0d of %0d checked, %0d cycles compared, %0d errors",
             rows_done, rows.size(), chk_cnt, err_cnt);
    if (timed_out || (err_cnt != 0) || (rows_done != rows.size())) begin
      $display("Finished with errors");
    end else begin
      $display("Finished with no errors");
    end
    $finish;
  end

endmodule

// ==== hdl/seq_age.sv ====
// --------------------
// Head pointer tracking and wrap-aware age of each squash source
// Ages feed the filter and the arbiter as plain unsigned values
// --------------------

`timescale 1ns/1ps

`include "squash_params.svh"

module seq_age
  import squash_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  // --------------------
  // Commit notification
  // --------------------

  input  logic     commit_val,
  input  seq_num_t commit_seq_num,

  // --------------------
  // Source sequence numbers
  // --------------------

  input  seq_num_t arb_seq_num [`SQUASH_NUM_SRC],

  // --------------------
  // Age outputs
  // --------------------

  output seq_num_t head,
  output seq_age_t arb_age [`SQUASH_NUM_SRC]
);

  // Next head after a commit
  seq_num_t head_next;

  // --------------------
  // Head register
  // --------------------

  // Oldest uncommitted instruction sits just past the last commit
  assign head_next = commit_seq_num + seq_num_t'(1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head <= '0;
    end else if (commit_val) begin
      // Wraps naturally at the top of the range
      head <= head_next;
    end
  end

  // --------------------
  // Age per source
  // --------------------

  // Modular distance from the head
  // Uses the head from before the edge
  always_comb begin
    for (int i = 0; i < `SQUASH_NUM_SRC; i++) begin
      arb_age[i] = seq_age_t'(arb_seq_num[i] - head);
    end
  end

endmodule

// ==== hdl/squash_arb_chain.sv ====
// --------------------
// Oldest-first chained arbiter over the squash sources
// One carry stage per source, last stage registered as the grant
// --------------------

`timescale 1ns/1ps

`include "squash_params.svh"

module squash_arb_chain
  import squash_pkg::*;
#(
  parameter int num_src = `SQUASH_NUM_SRC,
  // Width of the winning source index
  localparam int src_bits = (num_src > 1) ? $clog2(num_src) : 1
) (
  input  logic                clk,
  input  logic                rst_n,

  // --------------------
  // Filtered notifications
  // --------------------

  input  logic                live_val    [num_src],
  input  seq_age_t            arb_age     [num_src],
  input  seq_num_t            arb_seq_num [num_src],
  input  target_t             arb_target  [num_src],

  // --------------------
  // Registered grant
  // --------------------

  output logic                gnt_val,
  output seq_num_t            gnt_seq_num,
  output target_t             gnt_target,
  output logic [src_bits-1:0] gnt_src
);

  // Carried winner after each stage
  logic                c_val [num_src];
  seq_age_t            c_age [num_src];
  seq_num_t            c_seq [num_src];
  target_t             c_tgt [num_src];
  logic [src_bits-1:0] c_src [num_src];

  // --------------------
  // Chain
  // --------------------

  always_comb begin
    // First stage is source 0 as is
    c_val[0] = live_val[0];
    c_age[0] = arb_age[0];
    c_seq[0] = arb_seq_num[0];
    c_tgt[0] = arb_target[0];
    c_src[0] = '0;

    for (int i = 1; i < num_src; i++) begin
      // Strict compare keeps the lower index on a tie
      if (live_val[i] && (!c_val[i-1] || (arb_age[i] < c_age[i-1]))) begin
        c_val[i] = 1'b1;
        c_age[i] = arb_age[i];
        c_seq[i] = arb_seq_num[i];
        c_tgt[i] = arb_target[i];
        c_src[i] = src_bits'(i);
      end else begin
        // Carry the earlier winner
        c_val[i] = c_val[i-1];
        c_age[i] = c_age[i-1];
        c_seq[i] = c_seq[i-1];
        c_tgt[i] = c_tgt[i-1];
        c_src[i] = c_src[i-1];
      end
    end
  end

  // --------------------
  // Grant register
  // --------------------

  // Single cycle pulse with no back-pressure
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      gnt_val <= 1'b0;
    end else begin
      gnt_val <= c_val[num_src-1];
    end
  end

  // Grant payload from the final stage
  always_ff @(posedge clk) begin
    gnt_seq_num <= c_seq[num_src-1];
    gnt_target  <= c_tgt[num_src-1];
    gnt_src     <= c_src[num_src-1];
  end

endmodule

// ==== hdl/squash_filter.sv ====
// --------------------
// Stale squash filter
// Records the last granted squash and masks sources that are not older
// Released when the recorded instruction commits
// --------------------

`timescale 1ns/1ps

`include "squash_params.svh"

module squash_filter
  import squash_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  // --------------------
  // Incoming notifications
  // --------------------

  input  logic     arb_val  [`SQUASH_NUM_SRC],
  input  seq_age_t arb_age  [`SQUASH_NUM_SRC],
  input  seq_num_t head,

  // --------------------
  // Commit and grant
  // --------------------

  input  logic     commit_val,
  input  seq_num_t commit_seq_num,
  input  logic     gnt_val,
  input  seq_num_t gnt_seq_num,

  // Valids that survive the filter
  output logic     live_val [`SQUASH_NUM_SRC]
);

  filt_state_e state;

  // Sequence number of the squash in force
  seq_num_t    rec_seq;

  // Ages relative to the current head
  seq_age_t    rec_age;
  seq_age_t    gnt_age;

  // Grant replaces the recorded squash
  logic        take_gnt;

  // Recorded instruction commits
  logic        release_rec;

  // --------------------
  // Age of recorded and granted squash
  // --------------------

  assign rec_age = seq_age_t'(rec_seq - head);
  assign gnt_age = seq_age_t'(gnt_seq_num - head);

  // Any grant when idle, only an older one when holding
  assign take_gnt = gnt_val && ((state == filt_idle) || (gnt_age < rec_age));

  assign release_rec = commit_val && (state == filt_hold) && (commit_seq_num == rec_seq);

  // --------------------
  // State machine
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= filt_idle;
    end else if (take_gnt) begin
      // A newer record outranks a release in the same cycle
      state <= filt_hold;
    end else if (release_rec) begin
      state <= filt_idle;
    end
  end

  // Recorded squash loads on each taken grant
  always_ff @(posedge clk) begin
    if (take_gnt) begin
      rec_seq <= gnt_seq_num;
    end
  end

  // --------------------
  // Masking
  // --------------------

  // Live only if strictly older than the squash in force
  always_comb begin
    for (int i = 0; i < `SQUASH_NUM_SRC; i++) begin
      live_val[i] = arb_val[i] && ((state == filt_idle) || (arb_age[i] < rec_age));
    end
  end

endmodule

// ==== hdl/squash_params.svh ====
// --------------------
// Sizing macros for the squash arbitration stage
// Include in any file that sizes sequence numbers, targets or sources
// --------------------

`ifndef SQUASH_PARAMS_SVH
`define SQUASH_PARAMS_SVH

// --------------------
// Sequence numbers
// --------------------

// Bits in a sequence number that wraps at 2**bits
`define SQUASH_SEQ_BITS 6

// --------------------
// Redirect and sources
// --------------------

// Width of a redirect target address
`define SQUASH_TARGET_BITS 32

// Pipeline units that can raise a squash
`define SQUASH_NUM_SRC 3

`endif

// ==== hdl/squash_pkg.sv ====
// --------------------
// Shared types for the squash arbitration stage
// Import with a wildcard in the module header
// --------------------

`include "squash_params.svh"

package squash_pkg;

  // --------------------
  // Sequence numbers
  // --------------------

  // Raw sequence number that wraps around
  typedef logic [`SQUASH_SEQ_BITS-1:0] seq_num_t;

  // Distance from the head where smaller is older
  typedef logic [`SQUASH_SEQ_BITS-1:0] seq_age_t;

  // --------------------
  // Redirect
  // --------------------

  // Fetch redirect address carried with a squash
  typedef logic [`SQUASH_TARGET_BITS-1:0] target_t;

  // --------------------
  // Filter state
  // --------------------

  // Idle means no squash recorded and hold means one is in force
  typedef enum logic {
    filt_idle,
    filt_hold
  } filt_state_e;

endpackage

// ==== hdl/squash_unit.sv ====
// --------------------
// Squash arbitration stage top level
// Picks the oldest live squash and grants it one cycle later
// --------------------

`timescale 1ns/1ps

`include "squash_params.svh"

module squash_unit
  import squash_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  // --------------------
  // Squash notifications, one per source
  // --------------------

  input  logic     arb_val     [`SQUASH_NUM_SRC],
  input  seq_num_t arb_seq_num [`SQUASH_NUM_SRC],
  input  target_t  arb_target  [`SQUASH_NUM_SRC],

  // Commit advances the head
  input  logic     commit_val,
  input  seq_num_t commit_seq_num,

  // --------------------
  // Grant
  // --------------------

  output logic     gnt_val,
  output seq_num_t gnt_seq_num,
  output target_t  gnt_target,
  output logic [$clog2(`SQUASH_NUM_SRC)-1:0] gnt_src
);

  // Internal wiring
  seq_num_t head;
  seq_age_t arb_age  [`SQUASH_NUM_SRC];
  logic     live_val [`SQUASH_NUM_SRC];

  // Head and per-source age
  seq_age i_seq_age (
    .clk            (clk),
    .rst_n          (rst_n),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num),
    .arb_seq_num    (arb_seq_num),
    .head           (head),
    .arb_age        (arb_age)
  );

  // Drop notifications made stale by the recorded squash
  squash_filter i_squash_filter (
    .clk            (clk),
    .rst_n          (rst_n),
    .arb_val        (arb_val),
    .arb_age        (arb_age),
    .head           (head),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num),
    .gnt_val        (gnt_val),
    .gnt_seq_num    (gnt_seq_num),
    .live_val       (live_val)
  );

  // Oldest-first chain and grant register
  squash_arb_chain #(
    .num_src (`SQUASH_NUM_SRC)
  ) i_squash_arb_chain (
    .clk         (clk),
    .rst_n       (rst_n),
    .live_val    (live_val),
    .arb_age     (arb_age),
    .arb_seq_num (arb_seq_num),
    .arb_target  (arb_target),
    .gnt_val     (gnt_val),
    .gnt_seq_num (gnt_seq_num),
    .gnt_target  (gnt_target),
    .gnt_src     (gnt_src)
  );

endmodule

// ==== squash_sub.f ====
+incdir+hdl
hdl/squash_pkg.sv
hdl/seq_age.sv
hdl/squash_filter.sv
hdl/squash_arb_chain.sv
hdl/squash_unit.sv
bench/squash_checker.sv
bench/squash_unit_tb.sv
